// File: logic/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int NUM_REGS   = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0]   word_t;        // data, address and instruction
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [2:0]        alu_ctrl_t;
    typedef logic [1:0]        imm_src_t;
    typedef logic [1:0]        result_src_t;
    typedef logic [1:0]        pc_src_t;

    // major opcodes
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_RTYPE  = 7'b0110011;
    localparam opcode_t OPC_ITYPE  = 7'b0010011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    localparam alu_ctrl_t ALU_ADD = 3'b000;
    localparam alu_ctrl_t ALU_SUB = 3'b001;
    localparam alu_ctrl_t ALU_AND = 3'b010;
    localparam alu_ctrl_t ALU_OR  = 3'b011;
    localparam alu_ctrl_t ALU_XOR = 3'b100;
    localparam alu_ctrl_t ALU_SLL = 3'b101;

    localparam imm_src_t IMM_I = 2'b00;
    localparam imm_src_t IMM_S = 2'b01;
    localparam imm_src_t IMM_B = 2'b10;
    localparam imm_src_t IMM_J = 2'b11;

    localparam result_src_t RES_ALU = 2'b00;
    localparam result_src_t RES_MEM = 2'b01;
    localparam result_src_t RES_PC4 = 2'b10;

    localparam pc_src_t PC_PLUS4  = 2'b00;
    localparam pc_src_t PC_BRANCH = 2'b01;     // pc + imm
    localparam pc_src_t PC_ALU    = 2'b10;     // jalr target

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_t result_src;
        alu_ctrl_t   alu_ctrl;
        logic        alu_src;                  // 1 selects the immediate
        pc_src_t     pc_src;
    } ctrl_t;

endpackage

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  rv_pkg::word_t instr_i,
    input  logic          zero_i,
    output rv_pkg::ctrl_t ctrl_o,
    output rv_pkg::word_t imm_o
);

    rv_pkg::opcode_t  opcode;
    rv_pkg::funct3_t  funct3;
    logic             funct7_b5;
    rv_pkg::imm_src_t imm_src;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];              // sub vs add

    always_comb begin
        ctrl_o          = '0;                    // unknown opcode is a no-op
        ctrl_o.pc_src   = rv_pkg::PC_PLUS4;
        imm_src         = rv_pkg::IMM_I;
        case (opcode)
            rv_pkg::OPC_LOAD: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.alu_ctrl   = rv_pkg::ALU_ADD;
                ctrl_o.result_src = rv_pkg::RES_MEM;
            end
            rv_pkg::OPC_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_ctrl  = rv_pkg::ALU_ADD;
                imm_src          = rv_pkg::IMM_S;
            end
            rv_pkg::OPC_RTYPE: begin
                ctrl_o.reg_write = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: ctrl_o.alu_ctrl = funct7_b5 ? rv_pkg::ALU_SUB
                                                                    : rv_pkg::ALU_ADD;
                    rv_pkg::F3_AND:     ctrl_o.alu_ctrl = rv_pkg::ALU_AND;
                    rv_pkg::F3_OR:      ctrl_o.alu_ctrl = rv_pkg::ALU_OR;
                    rv_pkg::F3_XOR:     ctrl_o.alu_ctrl = rv_pkg::ALU_XOR;
                    default:            ctrl_o.alu_ctrl = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPC_ITYPE: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                case (funct3)
                    rv_pkg::F3_SLL: ctrl_o.alu_ctrl = rv_pkg::ALU_SLL;  // slli
                    default:        ctrl_o.alu_ctrl = rv_pkg::ALU_ADD;  // addi
                endcase
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl_o.alu_ctrl = rv_pkg::ALU_SUB;    // compare by subtraction
                imm_src         = rv_pkg::IMM_B;
                case (funct3)
                    rv_pkg::F3_BEQ: ctrl_o.pc_src = zero_i ? rv_pkg::PC_BRANCH
                                                           : rv_pkg::PC_PLUS4;
                    rv_pkg::F3_BNE: ctrl_o.pc_src = zero_i ? rv_pkg::PC_PLUS4
                                                           : rv_pkg::PC_BRANCH;
                    default:        ctrl_o.pc_src = rv_pkg::PC_PLUS4;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = rv_pkg::RES_PC4;
                ctrl_o.pc_src     = rv_pkg::PC_BRANCH;
                imm_src           = rv_pkg::IMM_J;
            end
            rv_pkg::OPC_JALR: begin
                ctrl_o.reg_write  = 1'b1;              // links pc + 4
                ctrl_o.result_src = rv_pkg::RES_PC4;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.alu_ctrl   = rv_pkg::ALU_ADD;
                ctrl_o.pc_src     = rv_pkg::PC_ALU;
            end
            default: ;
        endcase
    end

    // immediate generation, always sign-extended from bit 31
    always_comb begin
        case (imm_src)
            rv_pkg::IMM_S: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rv_pkg::IMM_B: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                    instr_i[30:25], instr_i[11:8], 1'b0};
            rv_pkg::IMM_J: imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                    instr_i[20], instr_i[30:21], 1'b0};
            default:       imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  logic              we_i,
    input  rv_pkg::word_t     wd_i,
    output rv_pkg::word_t     rd1_o,
    output rv_pkg::word_t     rd2_o
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin   // x0 stays zero
            regs[rd_i] <= wd_i;
        end
    end

    // combinational read ports
    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t a_i,
    input  rv_pkg::word_t rs2_i,
    input  rv_pkg::word_t imm_i,
    input  rv_pkg::ctrl_t ctrl_i,
    output rv_pkg::word_t y_o,
    output logic          zero_o
);

    rv_pkg::word_t b;
    logic [4:0]    shamt;

    assign b     = ctrl_i.alu_src ? imm_i : rs2_i;
    assign shamt = b[4:0];                      // only low 5 bits shift

    always_comb begin
        case (ctrl_i.alu_ctrl)
            rv_pkg::ALU_ADD: y_o = a_i + b;
            rv_pkg::ALU_SUB: y_o = a_i - b;
            rv_pkg::ALU_AND: y_o = a_i & b;
            rv_pkg::ALU_OR:  y_o = a_i | b;
            rv_pkg::ALU_XOR: y_o = a_i ^ b;
            rv_pkg::ALU_SLL: y_o = a_i << shamt;
            default:         y_o = a_i + b;
        endcase
    end

    assign zero_o = (y_o == '0);                // feeds branch decision

endmodule

// File: logic/result_select.sv
`timescale 1ns/1ps

module result_select (
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::word_t imm_i,
    input  rv_pkg::word_t alu_y_i,
    input  rv_pkg::word_t mem_rd_i,
    input  rv_pkg::ctrl_t ctrl_i,
    output rv_pkg::word_t wb_o,
    output rv_pkg::word_t pc_next_o
);

    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t pc_imm;

    assign pc_plus4 = pc_i + 32'd4;
    assign pc_imm   = pc_i + imm_i;             // branch and jal target

    // write-back source
    always_comb begin
        case (ctrl_i.result_src)
            rv_pkg::RES_MEM: wb_o = mem_rd_i;
            rv_pkg::RES_PC4: wb_o = pc_plus4;   // link value
            default:         wb_o = alu_y_i;
        endcase
    end

    always_comb begin
        case (ctrl_i.pc_src)
            rv_pkg::PC_BRANCH: pc_next_o = pc_imm;
            rv_pkg::PC_ALU:    pc_next_o = alu_y_i;  // rs1 + imm
            default:           pc_next_o = pc_plus4;
        endcase
    end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic          clk_i,
    input  logic          we_i,
    input  rv_pkg::word_t addr_i,
    input  rv_pkg::word_t wd_i,
    output rv_pkg::word_t rd_o
);

    rv_pkg::word_t            mem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_AW-1:0] idx;

    // drop byte offset, wrap at depth
    assign idx = addr_i[rv_pkg::DMEM_AW+1:2];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[idx] <= wd_i;
        end
    end

    assign rd_o = mem[idx];                     // async read for lw

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  rv_pkg::word_t     instr_i,
    output rv_pkg::word_t     pc_o,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_addr_o,
    output rv_pkg::word_t     rf_data_o,
    output logic              mem_we_o,
    output rv_pkg::word_t     mem_addr_o,
    output rv_pkg::word_t     mem_data_o
);

    rv_pkg::word_t     pc;
    rv_pkg::word_t     pc_next;
    rv_pkg::ctrl_t     ctrl;
    rv_pkg::word_t     imm;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     rd1;
    rv_pkg::word_t     rd2;
    rv_pkg::word_t     alu_y;
    logic              alu_zero;
    rv_pkg::word_t     mem_rd;
    rv_pkg::word_t     wb;
    logic              rf_we;
    logic              mem_we;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    // enables held low in reset, x0 writes never leave the core
    assign rf_we  = arst_n_i & ctrl.reg_write & (rd != '0);
    assign mem_we = arst_n_i & ctrl.mem_write;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    control_unit u_decode (
        .instr_i (instr_i),
        .zero_i  (alu_zero),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    reg_file u_rf (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd_i     (rd),
        .we_i     (rf_we),
        .wd_i     (wb),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    alu u_alu (
        .a_i    (rd1),
        .rs2_i  (rd2),
        .imm_i  (imm),
        .ctrl_i (ctrl),
        .y_o    (alu_y),
        .zero_o (alu_zero)
    );

    data_mem u_dmem (
        .clk_i  (clk_i),
        .we_i   (mem_we),
        .addr_i (alu_y),
        .wd_i   (rd2),
        .rd_o   (mem_rd)
    );

    result_select u_result (
        .pc_i      (pc),
        .imm_i     (imm),
        .alu_y_i   (alu_y),
        .mem_rd_i  (mem_rd),
        .ctrl_i    (ctrl),
        .wb_o      (wb),
        .pc_next_o (pc_next)
    );

    assign pc_o       = pc;
    assign rf_we_o    = rf_we;                  // retire trace
    assign rf_addr_o  = rd;
    assign rf_data_o  = wb;
    assign mem_we_o   = mem_we;                 // store trace
    assign mem_addr_o = alu_y;
    assign mem_data_o = rd2;

endmodule

// File: dv/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker (
    input logic              clk_i,
    input logic              arst_n_i,
    input rv_pkg::word_t     instr_i,
    input rv_pkg::word_t     pc_i,
    input logic              rf_we_i,
    input rv_pkg::reg_addr_t rf_addr_i,
    input logic              mem_we_i
);

    int unsigned violations = 0;

    pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pc_i[1:0] == 2'b00)
    else begin
        $error("pc_o %h is not word aligned", pc_i);
        violations++;
    end

    reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> (pc_i == '0 && !rf_we_i && !mem_we_i))
    else begin
        $error("core not quiet during reset");
        violations++;
    end

    no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rf_we_i |-> rf_addr_i != '0)
    else begin
        $error("register write to x0 on the retire trace");
        violations++;
    end

    store_only: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_we_i |-> instr_i[6:0] == rv_pkg::OPC_STORE)
    else begin
        $error("mem_we_o raised for opcode %h", instr_i[6:0]);
        violations++;
    end

endmodule

bind rv_core rv_core_checker u_checker (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .instr_i   (instr_i),
    .pc_i      (pc_o),
    .rf_we_i   (rf_we_o),
    .rf_addr_i (rf_addr_o),
    .mem_we_i  (mem_we_o)
);

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int            CLK_PERIOD   = 4;
    localparam int            RESET_CYCLES = 16;
    localparam int            PROG_MAX     = 64;
    localparam int            NUM_TESTS    = 6;
    localparam rv_pkg::word_t NOP          = 32'h0000_0013;   // addi x0, x0, 0

    logic              clk      = 1'b1;
    logic              arst_n   = 1'b1;
    rv_pkg::word_t     instr    = NOP;
    rv_pkg::word_t     pc;
    logic              rf_we;
    rv_pkg::reg_addr_t rf_addr;
    rv_pkg::word_t     rf_data;
    logic              mem_we;
    rv_pkg::word_t     mem_addr;
    rv_pkg::word_t     mem_data;

    rv_pkg::word_t     prog [PROG_MAX];            // instruction rom
    int                prog_len   = 0;
    logic              prog_ready = 1'b0;
    string             test_name [NUM_TESTS];
    rv_pkg::word_t     test_end [NUM_TESTS];       // byte address after each test
    int                n_built    = 0;

    rv_pkg::word_t     model_rf [rv_pkg::NUM_REGS];
    rv_pkg::word_t     model_mem [rv_pkg::DMEM_WORDS];
    rv_pkg::word_t     model_pc   = '0;
    logic              exp_rf_we;
    rv_pkg::reg_addr_t exp_rf_addr;
    rv_pkg::word_t     exp_rf_data;
    logic              exp_mem_we;
    rv_pkg::word_t     exp_mem_addr;
    rv_pkg::word_t     exp_mem_data;

    int seed            = 32'h7d465944;
    int errors          = 0;
    int errors_at_start = 0;
    int cur_test        = 0;
    int pass_cnt        = 0;
    int fail_cnt        = 0;

    rv_core UUT (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .instr_i    (instr),
        .pc_o       (pc),
        .rf_we_o    (rf_we),
        .rf_addr_o  (rf_addr),
        .rf_data_o  (rf_data),
        .mem_we_o   (mem_we),
        .mem_addr_o (mem_addr),
        .mem_data_o (mem_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
                                            input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
                                            input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t enc_r(input logic f7b5, input rv_pkg::reg_addr_t rs2,
                                            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3,
                                            input rv_pkg::reg_addr_t rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_RTYPE};
    endfunction

    function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input rv_pkg::reg_addr_t rs2,
                                            input rv_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
                                            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic int mem_index(input rv_pkg::word_t addr);
        return (addr >> 2) % rv_pkg::DMEM_WORDS;
    endfunction

    function automatic rv_pkg::word_t fetch(input rv_pkg::word_t addr);
        if ((addr >> 2) < prog_len) begin
            return prog[addr >> 2];
        end
        return NOP;                                // past the end of the program
    endfunction

    task automatic emit(input rv_pkg::word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic close_test(input string name);
        test_name[n_built] = name;
        test_end[n_built]  = prog_len * 4;
        n_built++;
    endtask

    // builds v in 11, 11 and 10 bit chunks so every addi immediate stays positive
    task automatic load_const(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t v);
        emit(enc_i({1'b0, v[31:21]}, 5'd0, 3'b000, rd, rv_pkg::OPC_ITYPE));
        emit(enc_i(12'd11, rd, 3'b001, rd, rv_pkg::OPC_ITYPE));
        emit(enc_i({1'b0, v[20:10]}, rd, 3'b000, rd, rv_pkg::OPC_ITYPE));
        emit(enc_i(12'd10, rd, 3'b001, rd, rv_pkg::OPC_ITYPE));
        emit(enc_i({2'b0, v[9:0]}, rd, 3'b000, rd, rv_pkg::OPC_ITYPE));
    endtask

    task automatic build_program();
        rv_pkg::word_t r;
        load_const(5'd1, $random(seed));
        load_const(5'd2, $random(seed));
        close_test("straight-line addi/slli");
        load_const(5'd8, $random(seed));
        load_const(5'd9, $random(seed));
        emit(enc_r(1'b0, 5'd9, 5'd8, 3'b000, 5'd3));   // add
        emit(enc_r(1'b1, 5'd9, 5'd8, 3'b000, 5'd4));   // sub
        emit(enc_r(1'b0, 5'd9, 5'd8, 3'b111, 5'd5));
        emit(enc_r(1'b0, 5'd9, 5'd8, 3'b110, 5'd6));
        emit(enc_r(1'b0, 5'd9, 5'd8, 3'b100, 5'd7));
        emit(enc_r(1'b0, 5'd9, 5'd8, 3'b000, 5'd0));   // x0 target
        close_test("r-type alu");
        emit(enc_i(12'h040, 5'd0, 3'b000, 5'd10, rv_pkg::OPC_ITYPE));
        emit(enc_s(12'd8, 5'd3, 5'd10));
        emit(enc_s(12'hffc, 5'd4, 5'd10));
        emit(enc_i(12'd8, 5'd10, 3'b010, 5'd11, rv_pkg::OPC_LOAD));
        emit(enc_i(12'hffc, 5'd10, 3'b010, 5'd12, rv_pkg::OPC_LOAD));
        close_test("store then load");
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b000));        // beq taken
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd13, rv_pkg::OPC_ITYPE));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001));        // bne not taken
        emit(enc_i(12'd2, 5'd0, 3'b000, 5'd14, rv_pkg::OPC_ITYPE));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd15, rv_pkg::OPC_ITYPE));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
        emit(enc_i(12'd4, 5'd0, 3'b000, 5'd16, rv_pkg::OPC_ITYPE));
        close_test("beq and bne");
        emit(enc_j(21'd8, 5'd17));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd19, rv_pkg::OPC_ITYPE));
        emit(enc_i(12'd12, 5'd17, 3'b000, 5'd18, rv_pkg::OPC_JALR));  // lands 16 past the jal
        emit(enc_i(12'd6, 5'd0, 3'b000, 5'd20, rv_pkg::OPC_ITYPE));
        close_test("jal and jalr");
        r = $random(seed);
        emit({r[31:7], 7'b1111111});
        r = $random(seed);
        emit({r[31:7], 7'b0001011});
        emit(enc_i(12'h123, 5'd0, 3'b000, 5'd21, rv_pkg::OPC_ITYPE));
        close_test("unknown opcode");
    endtask

    // architectural model of one instruction sets the expected trace
    task automatic step_model(input rv_pkg::word_t w);
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t     a;
        rv_pkg::word_t     b;
        rv_pkg::word_t     imm_i;
        rv_pkg::word_t     imm_s;
        rv_pkg::word_t     imm_b;
        rv_pkg::word_t     imm_j;
        rv_pkg::word_t     next_pc;
        logic              taken;
        rd      = w[11:7];
        a       = model_rf[w[19:15]];
        b       = model_rf[w[24:20]];
        imm_i   = $signed(w[31:20]);
        imm_s   = $signed({w[31:25], w[11:7]});
        imm_b   = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
        imm_j   = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
        next_pc = model_pc + 4;
        exp_rf_we    = 1'b0;
        exp_rf_addr  = rd;
        exp_rf_data  = '0;
        exp_mem_we   = 1'b0;
        exp_mem_addr = '0;
        exp_mem_data = '0;
        case (w[6:0])
            rv_pkg::OPC_LOAD: begin
                exp_rf_we   = 1'b1;
                exp_rf_data = model_mem[mem_index(a + imm_i)];
            end
            rv_pkg::OPC_STORE: begin
                exp_mem_we   = 1'b1;
                exp_mem_addr = a + imm_s;
                exp_mem_data = b;
            end
            rv_pkg::OPC_RTYPE: begin
                exp_rf_we = 1'b1;
                case (w[14:12])
                    3'b111:  exp_rf_data = a & b;
                    3'b110:  exp_rf_data = a | b;
                    3'b100:  exp_rf_data = a ^ b;
                    default: exp_rf_data = w[30] ? a - b : a + b;
                endcase
            end
            rv_pkg::OPC_ITYPE: begin
                exp_rf_we   = 1'b1;
                exp_rf_data = (w[14:12] == 3'b001) ? a << imm_i[4:0] : a + imm_i;
            end
            rv_pkg::OPC_BRANCH: begin
                taken = (w[14:12] == 3'b000) ? (a == b) : (a != b);
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            rv_pkg::OPC_JAL: begin
                exp_rf_we   = 1'b1;
                exp_rf_data = model_pc + 4;
                next_pc     = model_pc + imm_j;
            end
            rv_pkg::OPC_JALR: begin
                exp_rf_we   = 1'b1;
                exp_rf_data = model_pc + 4;
                next_pc     = a + imm_i;
            end
            default: ;                             // no architectural effect
        endcase
        if (rd == '0) begin
            exp_rf_we = 1'b0;
        end
        if (exp_rf_we) begin
            model_rf[rd] = exp_rf_data;
        end
        if (exp_mem_we) begin
            model_mem[mem_index(exp_mem_addr)] = exp_mem_data;
        end
        model_pc = next_pc;
    endtask

    task automatic report_mismatch(input string name, input rv_pkg::word_t exp,
                                   input rv_pkg::word_t act);
        $display("[FAIL] %s expected %h got %h at pc %h", name, exp, act, pc);
        errors++;
    endtask

    task automatic check_retire(input rv_pkg::word_t w);
        step_model(w);
        assert (rf_we === exp_rf_we) else report_mismatch("rf_we_o", exp_rf_we, rf_we);
        if (exp_rf_we) begin
            assert (rf_addr === exp_rf_addr) else report_mismatch("rf_addr_o", exp_rf_addr, rf_addr);
            assert (rf_data === exp_rf_data) else report_mismatch("rf_data_o", exp_rf_data, rf_data);
        end
        assert (mem_we === exp_mem_we) else report_mismatch("mem_we_o", exp_mem_we, mem_we);
        if (exp_mem_we) begin
            assert (mem_addr === exp_mem_addr)
                else report_mismatch("mem_addr_o", exp_mem_addr, mem_addr);
            assert (mem_data === exp_mem_data)
                else report_mismatch("mem_data_o", exp_mem_data, mem_data);
        end
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", cur_test + 1, test_name[cur_test]);
            pass_cnt++;
        end else begin
            $display("test %0d %s: %0d mismatches", cur_test + 1, test_name[cur_test],
                     errors - errors_at_start);
            fail_cnt++;
        end
        errors_at_start = errors;
        cur_test++;
    endtask

    initial begin
        for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        build_program();
        prog_ready = 1'b1;
        @(negedge clk);
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        while (cur_test < NUM_TESTS) begin
            assert (pc === model_pc) else report_mismatch("pc_o", model_pc, pc);
            if (model_pc == test_end[cur_test]) begin
                finish_test();
            end else begin
                instr = fetch(model_pc);
                #1;                                // trace settles mid-cycle
                check_retire(instr);
                @(negedge clk);
            end
        end
        $display("tests passed %0d, failed %0d, checker violations %0d",
                 pass_cnt, fail_cnt, UUT.u_checker.violations);
        if (fail_cnt == 0 && UUT.u_checker.violations == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog at four times the worst-case run length
    initial begin
        wait (prog_ready);
        #((prog_len + RESET_CYCLES) * CLK_PERIOD * 4);
        $display("run timed out before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: filelist.f
logic/rv_pkg.sv
logic/control_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/result_select.sv
logic/data_mem.sv
logic/rv_core.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/control_unit.sv
  - logic/reg_file.sv
  - logic/alu.sv
  - logic/result_select.sv
  - logic/data_mem.sv
  - logic/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_checker.sv
      - dv/rv_core_tb.sv
